// File: include/nn_weights.svh
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// ******************************
// layer coefficients
// ******************************

// weights by neuron, then by input index 0 to INPUTS-1.
localparam logic [31:0] NN_WEIGHTS [NEURONS][INPUTS] = '{
	'{
		32'h3F000000, 32'hBF800000, 32'h40000000, 32'h3E800000, // 0.5, -1.0, 2.0, 0.25.
		32'h3FC00000, 32'h00000000, 32'hBF000000, 32'h3F800000  // 1.5, 0.0, -0.5, 1.0.
	},
	'{
		32'hBF800000, 32'h3F000000, 32'hBE800000, 32'h40000000, // -1.0, 0.5, -0.25, 2.0.
		32'hBF000000, 32'h3F800000, 32'h00000000, 32'hBFC00000  // -0.5, 1.0, 0.0, -1.5.
	},
	'{
		32'h3E800000, 32'h3E800000, 32'h3F000000, 32'hBF000000, // 0.25, 0.25, 0.5, -0.5.
		32'h3F800000, 32'hC0000000, 32'h3F400000, 32'h3F000000  // 1.0, -2.0, 0.75, 0.5.
	}
};

// one bias per neuron.
localparam logic [31:0] NN_BIAS [NEURONS] = '{
	32'h3E800000, // 0.25.
	32'hBF000000, // -0.5.
	32'h3F800000  // 1.0.
};

`endif

// File: verilog/fp_pkg.sv
package fp_pkg;

	// ******************************
	// single precision format
	// ******************************

	localparam int FP_EXP_W = 8;
	localparam int FP_MAN_W = 23;
	localparam int FP_BIAS = 127;
	localparam int FP_EXP_MAX = 254; // largest finite exponent code.

	typedef struct packed {
		logic sign;
		logic [FP_EXP_W-1:0] exp;
		logic [FP_MAN_W-1:0] man;
	} fp_fields_t;

	// the same 32 bits seen as a raw word or as its fields.
	typedef union packed {
		logic [31:0] raw;
		fp_fields_t f;
	} fp_word_t;

endpackage

// File: verilog/nn_pkg.sv
package nn_pkg;

	// ******************************
	// layer shape
	// ******************************

	localparam int INPUTS = 8;
	localparam int NEURONS = 3;
	localparam int IDX_W = (INPUTS > NEURONS) ? $clog2(INPUTS) : $clog2(NEURONS);

	typedef struct packed {
		fp_pkg::fp_word_t data;
		logic last; // set on the final activation of a sample.
	} nn_in_t;

	typedef struct packed {
		logic [IDX_W-1:0] neuron;
		fp_pkg::fp_word_t data;
		logic last; // set on neuron NEURONS-1.
	} nn_out_t;

	// one multiply-add step of the shared float units.
	typedef struct packed {
		fp_pkg::fp_word_t act;
		fp_pkg::fp_word_t wgt;
		fp_pkg::fp_word_t acc;
	} mac_cmd_t;

endpackage

// File: verilog/fp_mult.sv
`timescale 1ns/10ps
module fp_mult (
	input logic clk,
	input logic rst_n,
	input logic start,
	input fp_pkg::fp_word_t a,
	input fp_pkg::fp_word_t b,
	output fp_pkg::fp_word_t prod,
	output logic done
);
	import fp_pkg::*;

	logic [FP_MAN_W:0] man_a;
	logic [FP_MAN_W:0] man_b;
	logic [2*FP_MAN_W+1:0] man_prod;
	logic [FP_EXP_W+1:0] exp_raw;
	logic [FP_EXP_W+1:0] exp_adj;
	fp_word_t res;

	assign man_a = {1'b1, a.f.man}; // hidden one restored.
	assign man_b = {1'b1, b.f.man};
	assign man_prod = (2*FP_MAN_W+2)'(man_a) * (2*FP_MAN_W+2)'(man_b);

	// the product lies in [1, 4), so the top bit decides the single normalizing shift.
	assign exp_raw = {2'b00, a.f.exp} + {2'b00, b.f.exp}
		+ (FP_EXP_W+2)'(man_prod[2*FP_MAN_W+1]);
	assign exp_adj = exp_raw - (FP_EXP_W+2)'(FP_BIAS);

	always_comb
	begin
		res.raw = '0; // zero, denormal or underflow gives +0.
		if (a.f.exp != '0 && b.f.exp != '0 && exp_raw > (FP_EXP_W+2)'(FP_BIAS))
		begin
			res.f.sign = a.f.sign ^ b.f.sign;
			if (exp_adj > (FP_EXP_W+2)'(FP_EXP_MAX))
			begin
				res.f.exp = FP_EXP_W'(FP_EXP_MAX); // saturate to the largest finite value.
				res.f.man = '1;
			end
			else
			begin
				res.f.exp = exp_adj[FP_EXP_W-1:0];
				if (man_prod[2*FP_MAN_W+1])
					res.f.man = man_prod[2*FP_MAN_W:FP_MAN_W+1];
				else
					res.f.man = man_prod[2*FP_MAN_W-1:FP_MAN_W];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start)
			prod <= res;
	end

endmodule

// File: verilog/fp_add.sv
`timescale 1ns/10ps
module fp_add (
	input logic clk,
	input logic rst_n,
	input logic start,
	input fp_pkg::fp_word_t a,
	input fp_pkg::fp_word_t b,
	output fp_pkg::fp_word_t sum,
	output logic done
);
	import fp_pkg::*;

	fp_word_t big;
	fp_word_t lesser;
	fp_word_t res;
	logic [FP_EXP_W-1:0] exp_diff;
	logic [FP_MAN_W:0] man_big;
	logic [FP_MAN_W:0] man_small;
	logic [FP_MAN_W+1:0] man_sum;
	logic [FP_MAN_W:0] man_norm;
	logic [4:0] lz;
	logic [FP_EXP_W:0] exp_inc;

	// ******************************
	// alignment and mantissa add
	// ******************************

	always_comb
	begin
		// exponent sits above the mantissa, so the raw bits order by magnitude.
		if (a.raw[FP_EXP_W+FP_MAN_W-1:0] >= b.raw[FP_EXP_W+FP_MAN_W-1:0])
		begin
			big = a;
			lesser = b;
		end
		else
		begin
			big = b;
			lesser = a;
		end
		exp_diff = big.f.exp - lesser.f.exp;
		man_big = {1'b1, big.f.man};
		man_small = {1'b1, lesser.f.man} >> exp_diff; // bits shifted out are lost.
		if (big.f.sign == lesser.f.sign)
			man_sum = {1'b0, man_big} + {1'b0, man_small};
		else
			man_sum = {1'b0, man_big} - {1'b0, man_small};
	end

	// the highest set bit gives the leading-zero count.
	always_comb
	begin
		lz = 5'(FP_MAN_W + 1);
		for (int i = 0; i <= FP_MAN_W; i++)
			if (man_sum[i])
				lz = 5'(FP_MAN_W - i);
	end

	assign man_norm = man_sum[FP_MAN_W:0] << lz;
	assign exp_inc = {1'b0, big.f.exp} + 1'b1;

	// ******************************
	// normalization
	// ******************************

	always_comb
	begin
		res.raw = '0;
		if (a.f.exp == '0)
		begin
			if (b.f.exp != '0)
				res = b;
		end
		else if (b.f.exp == '0)
			res = a;
		else if (man_sum[FP_MAN_W+1])
		begin
			res.f.sign = big.f.sign; // a carry out shifts the mantissa right by one.
			if (exp_inc > (FP_EXP_W+1)'(FP_EXP_MAX))
			begin
				res.f.exp = FP_EXP_W'(FP_EXP_MAX);
				res.f.man = '1;
			end
			else
			begin
				res.f.exp = exp_inc[FP_EXP_W-1:0];
				res.f.man = man_sum[FP_MAN_W:1];
			end
		end
		else if (man_sum != '0 && {3'b000, lz} < big.f.exp)
		begin
			res.f.sign = big.f.sign;
			res.f.exp = big.f.exp - {3'b000, lz};
			res.f.man = man_norm[FP_MAN_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start)
			sum <= res;
	end

	// every result is normal or exactly +0, never a denormal pattern.
	assert property (@(posedge clk) disable iff (!rst_n)
		done && sum.f.exp == '0 |-> sum.f.man == '0);

endmodule

// File: verilog/weight_rom.sv
`timescale 1ns/10ps
module weight_rom (
	input logic [nn_pkg::IDX_W-1:0] neuron,
	input logic [nn_pkg::IDX_W-1:0] index,
	input logic bias_sel,
	output fp_pkg::fp_word_t coef
);
	import nn_pkg::*;

	`include "nn_weights.svh"

	always_comb
	begin
		coef.raw = '0; // indices out of range read as +0.
		for (int n = 0; n < NEURONS; n++)
		begin
			if (neuron == IDX_W'(n))
			begin
				if (bias_sel)
					coef.raw = NN_BIAS[n];
				else
				begin
					for (int i = 0; i < INPUTS; i++)
						if (index == IDX_W'(i))
							coef.raw = NN_WEIGHTS[n][i];
				end
			end
		end
	end

endmodule

// File: verilog/neuron_ctrl.sv
`timescale 1ns/10ps
module neuron_ctrl (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input nn_pkg::nn_in_t in_beat,
	output logic out_valid,
	input logic out_ready,
	output nn_pkg::nn_out_t out_beat,
	output logic [nn_pkg::IDX_W-1:0] rom_neuron,
	output logic [nn_pkg::IDX_W-1:0] rom_index,
	output logic rom_bias_sel,
	input fp_pkg::fp_word_t coef,
	output logic mul_start,
	output nn_pkg::mac_cmd_t mac_cmd,
	input fp_pkg::fp_word_t prod,
	input logic prod_done,
	output logic add_start,
	input fp_pkg::fp_word_t sum,
	input logic sum_done
);
	import fp_pkg::*;
	import nn_pkg::*;

	typedef enum logic [2:0] {S_COLLECT, S_BIAS, S_MUL, S_ADD, S_EMIT, S_WAIT} state_t;

	state_t state;
	logic [IDX_W-1:0] idx; // write pointer while collecting, input index while computing.
	logic [IDX_W-1:0] neu;
	fp_word_t acc;
	fp_word_t act_buf [INPUTS];
	logic in_fire;
	logic sample_done;

	assign in_ready = (state == S_COLLECT);
	assign in_fire = in_valid && in_ready;
	assign sample_done = in_beat.last && (idx == IDX_W'(INPUTS - 1));
	assign mul_start = (state == S_MUL);
	assign add_start = (state == S_ADD) && prod_done;

	// the bias of neuron 0 is read during collect so it loads with the last beat.
	assign rom_neuron = neu;
	assign rom_index = idx;
	assign rom_bias_sel = (state == S_COLLECT) || (state == S_BIAS);

	// act carries the product to the adder during the add step.
	assign mac_cmd.act = (state == S_ADD) ? prod : act_buf[idx];
	assign mac_cmd.wgt = coef;
	assign mac_cmd.acc = acc;

	// ******************************
	// sequencer
	// ******************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_COLLECT;
			idx <= '0;
			neu <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			case (state)
				S_COLLECT:
					if (in_fire)
					begin
						if (sample_done)
						begin
							idx <= '0;
							state <= S_MUL;
						end
						else if (in_beat.last || idx == IDX_W'(INPUTS - 1))
							idx <= '0; // malformed sample is dropped.
						else
							idx <= idx + 1'b1;
					end
				S_BIAS:
					state <= S_MUL;
				S_MUL:
					state <= S_ADD;
				S_ADD:
					if (prod_done)
					begin
						if (idx == IDX_W'(INPUTS - 1))
						begin
							idx <= '0;
							state <= S_EMIT;
						end
						else
						begin
							idx <= idx + 1'b1;
							state <= S_MUL;
						end
					end
				S_EMIT:
					if (sum_done)
					begin
						out_valid <= 1'b1;
						state <= S_WAIT;
					end
				S_WAIT:
					if (out_ready)
					begin
						out_valid <= 1'b0;
						if (neu == IDX_W'(NEURONS - 1))
						begin
							neu <= '0;
							state <= S_COLLECT;
						end
						else
						begin
							neu <= neu + 1'b1;
							state <= S_BIAS;
						end
					end
				default:
					state <= S_COLLECT;
			endcase
		end
	end

	// ******************************
	// data registers
	// ******************************

	always_ff @(posedge clk)
	begin
		if (in_fire)
			act_buf[idx] <= in_beat.data;
		if ((in_fire && sample_done) || state == S_BIAS)
			acc <= coef;
		else if (state == S_MUL && sum_done)
			acc <= sum; // sum of the previous add step.
		if (state == S_EMIT && sum_done)
		begin
			out_beat.neuron <= neu;
			out_beat.data <= sum.f.sign ? '0 : sum; // relu maps -0 to +0 as well.
			out_beat.last <= (neu == IDX_W'(NEURONS - 1));
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_beat));

	// each product reaches the adder on the cycle after its multiply.
	assert property (@(posedge clk) disable iff (!rst_n) mul_start |=> add_start);

endmodule

// File: verilog/neuron_top.sv
`timescale 1ns/10ps
module neuron_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input nn_pkg::nn_in_t in_beat,
	output logic out_valid,
	input logic out_ready,
	output nn_pkg::nn_out_t out_beat
);
	import fp_pkg::*;
	import nn_pkg::*;

	logic [IDX_W-1:0] rom_neuron;
	logic [IDX_W-1:0] rom_index;
	logic rom_bias_sel;
	fp_word_t coef;
	fp_word_t prod;
	fp_word_t sum;
	mac_cmd_t mac_cmd;
	logic mul_start;
	logic prod_done;
	logic add_start;
	logic sum_done;

	neuron_ctrl ctrl0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_beat(in_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat),
		.rom_neuron(rom_neuron),
		.rom_index(rom_index),
		.rom_bias_sel(rom_bias_sel),
		.coef(coef),
		.mul_start(mul_start),
		.mac_cmd(mac_cmd),
		.prod(prod),
		.prod_done(prod_done),
		.add_start(add_start),
		.sum(sum),
		.sum_done(sum_done));

	weight_rom rom0 (
		.neuron(rom_neuron),
		.index(rom_index),
		.bias_sel(rom_bias_sel),
		.coef(coef));

	fp_mult mult0 (
		.clk(clk),
		.rst_n(rst_n),
		.start(mul_start),
		.a(mac_cmd.act),
		.b(mac_cmd.wgt),
		.prod(prod),
		.done(prod_done));

	fp_add add0 (
		.clk(clk),
		.rst_n(rst_n),
		.start(add_start),
		.a(mac_cmd.act), // holds the product during the add step.
		.b(mac_cmd.acc),
		.sum(sum),
		.done(sum_done));

endmodule

// File: tests/neuron_tb.sv
`timescale 1ns/10ps
module neuron_tb;
	import fp_pkg::*;
	import nn_pkg::*;

	localparam int SAMPLES = 6;
	localparam int WAIT_LIMIT = 500; // cycles allowed for any single wait.
	localparam logic [31:0] SEED = 32'h11d05ba5;

	// ******************************
	// samples and hand-worked results
	// ******************************

	localparam logic [31:0] ACT_TABLE [SAMPLES][INPUTS] = '{
		'{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000,
			32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000}, // all 1.0.
		'{32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000}, // all zero.
		'{32'h00000000, 32'h00000000, 32'h00000000, 32'hBF800000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000}, // neuron 0 cancels.
		'{32'h40000000, 32'h3F800000, 32'h40800000, 32'h3F000000,
			32'hBF800000, 32'h40400000, 32'h3FC00000, 32'hC0000000},
		'{32'h3F800000, 32'h00000000, 32'h3F000000, 32'h00000000,
			32'h40000000, 32'h00000000, 32'h00000000, 32'h00000000},
		'{32'h00000000, 32'h00000000, 32'h00000000, 32'h3F800000,
			32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000}
	};

	localparam logic [31:0] EXP_TABLE [SAMPLES][NEURONS] = '{
		'{32'h40800000, 32'h00000000, 32'h3FE00000}, // 4.0, relu(-0.25), 1.75.
		'{32'h3E800000, 32'h00000000, 32'h3F800000}, // relu of each bias.
		'{32'h00000000, 32'h00000000, 32'h3FC00000}, // 0.0, relu(-2.5), 1.5.
		'{32'h40840000, 32'h40900000, 32'h00000000}, // 4.125, 4.5, relu(-3.375).
		'{32'h40980000, 32'h00000000, 32'h40600000}, // 4.75, relu(-2.625), 3.5.
		'{32'h3F000000, 32'h3FC00000, 32'h3F000000}  // 0.5, 1.5, 0.5.
	};

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	nn_in_t in_beat;
	logic out_valid;
	logic out_ready;
	nn_out_t out_beat;
	int results_seen;
	logic [31:0] in_rng;
	logic [31:0] out_rng;

	neuron_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_beat(in_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat));

	always #20 clk = ~clk;

	// fibonacci lfsr with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("FAILED at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
	endtask

	task automatic check_word(input string name, input fp_word_t expected,
		input fp_word_t actual);
		if (actual.raw !== expected.raw)
			abort_run($sformatf("FAILED at %0t: %s expected %h, got %h",
				$time, name, expected.raw, actual.raw));
	endtask

	task automatic check_beat_ctrl(input logic [IDX_W-1:0] neuron, input logic last,
		input nn_out_t actual);
		if (actual.neuron !== neuron)
			abort_run($sformatf("FAILED at %0t: out_beat.neuron expected %0d, got %0d",
				$time, neuron, actual.neuron));
		if (actual.last !== last)
			abort_run($sformatf("FAILED at %0t: out_beat.last expected %b, got %b",
				$time, last, actual.last));
	endtask

	// ******************************
	// input and output streams
	// ******************************

	task automatic send_beat(input fp_word_t data, input logic last, input int sample,
		input logic first);
		int waited;
		logic [1:0] gap;
		gap = '0;
		repeat (2)
		begin
			in_rng = lfsr_next(in_rng);
			gap = {gap[0], in_rng[0]};
		end
		repeat (gap) @(negedge clk);
		in_beat.data = data;
		in_beat.last = last;
		in_valid = 1'b1;
		waited = 0;
		while (!in_ready)
		begin
			if (waited == WAIT_LIMIT)
				abort_run("timeout while waiting for in_ready to rise");
			@(negedge clk);
			waited++;
		end
		// the beat transfers on the coming rising edge.
		if (first && results_seen != sample * NEURONS)
			abort_run("a new sample was accepted before all results of the previous one");
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic send_samples();
		for (int s = 0; s < SAMPLES; s++)
			for (int i = 0; i < INPUTS; i++)
				send_beat(ACT_TABLE[s][i], i == INPUTS - 1, s, i == 0);
	endtask

	task automatic collect_results();
		nn_out_t held;
		logic pending;
		logic accepted;
		int waited;
		int s;
		int n;
		pending = 1'b0;
		held = '0;
		for (int r = 0; r < SAMPLES * NEURONS; r++)
		begin
			s = r / NEURONS;
			n = r % NEURONS;
			accepted = 1'b0;
			waited = 0;
			while (!accepted)
			begin
				if (waited == WAIT_LIMIT)
					abort_run("timeout while waiting for a result to be accepted");
				if (pending)
				begin
					check_bit("out_valid", 1'b1, out_valid); // a held beat may not vanish.
					check_word("out_beat.data", held.data, out_beat.data);
					check_beat_ctrl(held.neuron, held.last, out_beat);
				end
				if (out_valid)
					check_bit("in_ready", 1'b0, in_ready);
				out_rng = lfsr_next(out_rng);
				out_ready = out_rng[0];
				if (out_valid && out_ready)
				begin
					check_beat_ctrl(IDX_W'(n), n == NEURONS - 1, out_beat);
					check_word("out_beat.data", EXP_TABLE[s][n], out_beat.data);
					results_seen++;
					accepted = 1'b1;
					pending = 1'b0;
				end
				else
				begin
					pending = out_valid;
					held = out_beat;
				end
				@(negedge clk);
				waited++;
			end
		end
		out_ready = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		results_seen = 0;
		in_rng = SEED;
		out_rng = SEED;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("in_ready", 1'b1, in_ready);
		fork
			send_samples();
			collect_results();
		join
		// after the final accept the layer is idle and ready for the next sample.
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("in_ready", 1'b1, in_ready);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: all.f
+incdir+include
verilog/fp_pkg.sv
verilog/nn_pkg.sv
verilog/fp_mult.sv
verilog/fp_add.sv
verilog/weight_rom.sv
verilog/neuron_ctrl.sv
verilog/neuron_top.sv
tests/neuron_tb.sv

// File: run.sh
#!/bin/sh
# Builds the neuron layer testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f all.f \
	--top-module neuron_tb \
	--Mdir obj_dir \
	-o neuron_sim

./obj_dir/neuron_sim
